// File: design/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter import mips_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  inst_req,
    input  word_t inst_addr,
    input  logic  data_req,
    input  logic  data_we,
    input  word_t data_addr,
    input  word_t data_wdata,
    input  word_t mem_rdata,
    input  logic  mem_ack,
    output logic  inst_ack,
    output word_t inst_rdata,
    output logic  data_ack,
    output word_t data_rdata,
    output logic  mem_req,
    output logic  mem_we,
    output word_t mem_addr,
    output word_t mem_wdata
);
    arb_state_e state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= arb_idle;
        end else begin
            case (state)
                // data side wins a tie
                arb_idle: begin
                    if (data_req) begin
                        state <= arb_data;
                    end else if (inst_req) begin
                        state <= arb_inst;
                    end
                end
                arb_inst, arb_data: begin
                    if (mem_ack) begin
                        state <= arb_idle;
                    end
                end
                default: state <= arb_idle;
            endcase
        end
    end

    assign mem_req   = (state != arb_idle);
    assign mem_we    = (state == arb_data) && data_we;
    assign mem_addr  = (state == arb_data) ? data_addr : inst_addr;
    assign mem_wdata = data_wdata;

    assign inst_ack   = (state == arb_inst) && mem_ack;
    assign data_ack   = (state == arb_data) && mem_ack;
    assign inst_rdata = (state == arb_inst) ? mem_rdata : 32'd0;
    assign data_rdata = (state == arb_data) ? mem_rdata : 32'd0;

endmodule

// File: design/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import mips_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      fs_to_ds_valid,
    input  word_t     fs_inst,
    input  word_t     fs_pc,
    input  logic      es_allowin,
    input  logic      es_we,
    input  reg_addr_t es_dest,
    input  logic      es_fwd_valid,
    input  word_t     es_fwd_data,
    input  logic      ms_we,
    input  reg_addr_t ms_dest,
    input  logic      ms_fwd_valid,
    input  word_t     ms_fwd_data,
    input  logic      rf_we,
    input  reg_addr_t rf_waddr,
    input  word_t     rf_wdata,
    output logic      ds_allowin,
    output logic      ds_to_es_valid,
    output alu_op_e   ds_alu_op,
    output word_t     ds_src1,
    output word_t     ds_src2,
    output word_t     ds_store_data,
    output reg_addr_t ds_dest,
    output logic      ds_gr_we,
    output logic      ds_load,
    output logic      ds_store,
    output logic      br_taken,
    output word_t     br_target
);
    logic   ds_valid;
    logic   ds_ready_go;
    word_t  ds_inst;
    word_t  ds_pc;
    word_t  rf_rdata1;
    word_t  rf_rdata2;
    word_t  rs_value;
    word_t  rt_value;
    br_op_e br_op;
    logic   br_cond;

    wire [5:0]      op      = ds_inst[31:26];
    wire reg_addr_t rs      = ds_inst[25:21];
    wire reg_addr_t rt      = ds_inst[20:16];
    wire reg_addr_t rd      = ds_inst[15:11];
    wire [4:0]      sa      = ds_inst[10:6];
    wire [5:0]      func    = ds_inst[5:0];
    wire [15:0]     imm     = ds_inst[15:0];
    wire [25:0]     jidx    = ds_inst[25:0];
    wire word_t     slot_pc = ds_pc + 32'd4;

    wire special    = (op == 6'h00);
    wire inst_addu  = special && func == 6'h21;
    wire inst_subu  = special && func == 6'h23;
    wire inst_and   = special && func == 6'h24;
    wire inst_or    = special && func == 6'h25;
    wire inst_slt   = special && func == 6'h2a;
    wire inst_sll   = special && func == 6'h00;
    wire inst_jr    = special && func == 6'h08;
    wire inst_addiu = (op == 6'h09);
    wire inst_ori   = (op == 6'h0d);
    wire inst_lui   = (op == 6'h0f);
    wire inst_lw    = (op == 6'h23);
    wire inst_sw    = (op == 6'h2b);
    wire inst_beq   = (op == 6'h04);
    wire inst_bne   = (op == 6'h05);
    wire inst_j     = (op == 6'h02);
    wire inst_jal   = (op == 6'h03);

    wire r_alu     = inst_addu | inst_subu | inst_and | inst_or | inst_slt | inst_sll;
    wire dst_is_rt = inst_addiu | inst_ori | inst_lui | inst_lw;
    wire rs_used   = r_alu & ~inst_sll | inst_addiu | inst_ori | inst_lw | inst_sw
                   | inst_beq | inst_bne | inst_jr;
    wire rt_used   = r_alu | inst_beq | inst_bne | inst_sw;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
        if (fs_to_ds_valid && ds_allowin) begin
            ds_inst <= fs_inst;
            ds_pc   <= fs_pc;
        end
    end

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rs),
        .raddr2 (rt),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    // execute holds the younger of the two older writers
    wire rs_hit_es = rs_used && rs != 5'd0 && es_we && rs == es_dest;
    wire rs_hit_ms = rs_used && rs != 5'd0 && ms_we && rs == ms_dest;
    wire rt_hit_es = rt_used && rt != 5'd0 && es_we && rt == es_dest;
    wire rt_hit_ms = rt_used && rt != 5'd0 && ms_we && rt == ms_dest;
    wire rs_ok     = rs_hit_es ? es_fwd_valid : (!rs_hit_ms || ms_fwd_valid);
    wire rt_ok     = rt_hit_es ? es_fwd_valid : (!rt_hit_ms || ms_fwd_valid);

    assign ds_ready_go    = rs_ok && rt_ok;
    assign ds_allowin     = !ds_valid || ds_ready_go && es_allowin;
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    assign rs_value = rs_hit_es ? es_fwd_data : rs_hit_ms ? ms_fwd_data : rf_rdata1;
    assign rt_value = rt_hit_es ? es_fwd_data : rt_hit_ms ? ms_fwd_data : rf_rdata2;

    assign ds_alu_op = inst_subu            ? alu_sub :
                       inst_and             ? alu_and :
                       (inst_or | inst_ori) ? alu_or  :
                       inst_slt             ? alu_slt :
                       inst_sll             ? alu_sll :
                       inst_lui             ? alu_lui :
                                              alu_add;

    // link value pc+8 comes out of the alu
    assign ds_src1 = inst_jal ? ds_pc : inst_sll ? rt_value : rs_value;
    assign ds_src2 = inst_jal                         ? 32'd8 :
                     inst_sll                         ? {27'd0, sa} :
                     (inst_ori | inst_lui)            ? {16'd0, imm} :
                     (inst_addiu | inst_lw | inst_sw) ? {{16{imm[15]}}, imm} :
                                                        rt_value;

    assign ds_store_data = rt_value;
    assign ds_dest       = inst_jal ? 5'd31 : dst_is_rt ? rt : rd;
    assign ds_gr_we      = (r_alu | dst_is_rt | inst_jal) && ds_dest != 5'd0;
    assign ds_load       = inst_lw;
    assign ds_store      = inst_sw;

    assign br_op = inst_beq           ? br_beq :
                   inst_bne           ? br_bne :
                   (inst_j | inst_jal) ? br_j  :
                   inst_jr            ? br_jr  :
                                        br_none;

    always_comb begin
        case (br_op)
            br_beq:      br_cond = (rs_value == rt_value);
            br_bne:      br_cond = (rs_value != rt_value);
            br_j, br_jr: br_cond = 1'b1;
            default:     br_cond = 1'b0;
        endcase
    end

    // only resolve once operands are final
    assign br_taken  = ds_valid && ds_ready_go && br_cond;
    assign br_target = (br_op == br_jr) ? rs_value :
                       (br_op == br_j)  ? {slot_pc[31:28], jidx, 2'b00} :
                                          slot_pc + {{14{imm[15]}}, imm, 2'b00};

endmodule

// File: design/exec_stage.sv
`timescale 1ns/1ps

module exec_stage import mips_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      ds_to_es_valid,
    input  alu_op_e   ds_alu_op,
    input  word_t     ds_src1,
    input  word_t     ds_src2,
    input  word_t     ds_store_data,
    input  reg_addr_t ds_dest,
    input  logic      ds_gr_we,
    input  logic      ds_load,
    input  logic      ds_store,
    input  logic      ms_allowin,
    output logic      es_allowin,
    output logic      es_to_ms_valid,
    output word_t     es_result,
    output word_t     es_store_data,
    output reg_addr_t es_dest_out,
    output logic      es_gr_we_out,
    output logic      es_load_out,
    output logic      es_store_out,
    output logic      es_we,
    output reg_addr_t es_dest,
    output logic      es_fwd_valid,
    output word_t     es_fwd_data
);
    logic    es_valid;
    alu_op_e alu_op_r;
    word_t   src1_r;
    word_t   src2_r;

    // single cycle alu, never holds on its own
    assign es_allowin     = !es_valid || ms_allowin;
    assign es_to_ms_valid = es_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_to_es_valid;
        end
        if (ds_to_es_valid && es_allowin) begin
            alu_op_r      <= ds_alu_op;
            src1_r        <= ds_src1;
            src2_r        <= ds_src2;
            es_store_data <= ds_store_data;
            es_dest_out   <= ds_dest;
            es_gr_we_out  <= ds_gr_we;
            es_load_out   <= ds_load;
            es_store_out  <= ds_store;
        end
    end

    always_comb begin
        case (alu_op_r)
            alu_add: es_result = src1_r + src2_r;
            alu_sub: es_result = src1_r - src2_r;
            alu_and: es_result = src1_r & src2_r;
            alu_or:  es_result = src1_r | src2_r;
            alu_slt: es_result = {31'd0, $signed(src1_r) < $signed(src2_r)};
            alu_sll: es_result = src1_r << src2_r[4:0];
            alu_lui: es_result = {src2_r[15:0], 16'd0};
            default: es_result = 32'd0;
        endcase
    end

    // a load result is an address here, not forwardable
    assign es_we        = es_valid && es_gr_we_out;
    assign es_dest      = es_dest_out;
    assign es_fwd_valid = es_we && !es_load_out;
    assign es_fwd_data  = es_result;

endmodule

// File: design/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import mips_pkg::*; #(
    parameter word_t reset_pc = 32'h0
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  ds_allowin,
    input  logic  br_taken,
    input  word_t br_target,
    input  logic  inst_ack,
    input  word_t inst_rdata,
    output logic  inst_req,
    output word_t inst_addr,
    output logic  fs_to_ds_valid,
    output word_t fs_inst,
    output word_t fs_pc
);
    word_t pc;
    logic  fs_valid;
    logic  redirect_pending;
    word_t redirect_pc;

    // request only into an empty slot, pc holds until the ack
    assign inst_req       = !fs_valid;
    assign inst_addr      = pc;
    assign fs_to_ds_valid = fs_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc               <= reset_pc;
            fs_valid         <= 1'b0;
            redirect_pending <= 1'b0;
        end else if (inst_ack) begin
            fs_valid         <= 1'b1;
            redirect_pending <= 1'b0;
            pc <= br_taken ? br_target : redirect_pending ? redirect_pc : pc + 32'd4;
        end else begin
            if (fs_valid && ds_allowin) begin
                fs_valid <= 1'b0;
            end
            // delay slot still on the bus, jump after it lands
            if (br_taken && !fs_valid) begin
                redirect_pending <= 1'b1;
            end else if (br_taken) begin
                pc <= br_target;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (inst_ack) begin
            fs_inst <= inst_rdata;
            fs_pc   <= pc;
        end
        if (br_taken) begin
            redirect_pc <= br_target;
        end
    end

endmodule

// File: design/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage import mips_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      es_to_ms_valid,
    input  word_t     es_result,
    input  word_t     es_store_data,
    input  reg_addr_t es_dest_out,
    input  logic      es_gr_we_out,
    input  logic      es_load_out,
    input  logic      es_store_out,
    input  logic      data_ack,
    input  word_t     data_rdata,
    output logic      ms_allowin,
    output logic      data_req,
    output logic      data_we,
    output word_t     data_addr,
    output word_t     data_wdata,
    output logic      ms_we,
    output reg_addr_t ms_dest,
    output logic      ms_fwd_valid,
    output word_t     ms_fwd_data,
    output logic      rf_we,
    output reg_addr_t rf_waddr,
    output word_t     rf_wdata,
    output logic      wb_valid,
    output reg_addr_t wb_dest,
    output word_t     wb_data
);
    logic      ms_valid;
    logic      ms_ready_go;
    logic      mem_op;
    word_t     result_r;
    word_t     store_data_r;
    reg_addr_t dest_r;
    logic      gr_we_r;
    logic      load_r;
    logic      store_r;

    // loads and stores wait here for the data ack
    assign mem_op      = load_r || store_r;
    assign ms_ready_go = !mem_op || data_ack;
    assign ms_allowin  = !ms_valid || ms_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_to_ms_valid;
        end
        if (es_to_ms_valid && ms_allowin) begin
            result_r     <= es_result;
            store_data_r <= es_store_data;
            dest_r       <= es_dest_out;
            gr_we_r      <= es_gr_we_out;
            load_r       <= es_load_out;
            store_r      <= es_store_out;
        end
    end

    assign data_req   = ms_valid && mem_op;
    assign data_we    = store_r;
    assign data_addr  = result_r;
    assign data_wdata = store_data_r;

    assign rf_we    = ms_valid && gr_we_r && ms_ready_go;
    assign rf_waddr = dest_r;
    assign rf_wdata = load_r ? data_rdata : result_r;

    assign ms_we        = ms_valid && gr_we_r;
    assign ms_dest      = dest_r;
    assign ms_fwd_valid = ms_we && (!load_r || data_ack);
    assign ms_fwd_data  = rf_wdata;

    assign wb_valid = rf_we;
    assign wb_dest  = rf_waddr;
    assign wb_data  = rf_wdata;

endmodule

// File: design/mips_core.sv
`timescale 1ns/1ps

module mips_core import mips_pkg::*; #(
    parameter word_t reset_pc = 32'h0
) (
    input  logic      clk,
    input  logic      reset,
    input  word_t     mem_rdata,
    input  logic      mem_ack,
    output logic      mem_req,
    output logic      mem_we,
    output word_t     mem_addr,
    output word_t     mem_wdata,
    output logic      wb_valid,
    output reg_addr_t wb_dest,
    output word_t     wb_data
);
    // fetch and decode handshake, branch redirect
    logic      ds_allowin;
    logic      fs_to_ds_valid;
    word_t     fs_inst;
    word_t     fs_pc;
    logic      br_taken;
    word_t     br_target;

    // decode to execute
    logic      es_allowin;
    logic      ds_to_es_valid;
    alu_op_e   ds_alu_op;
    word_t     ds_src1;
    word_t     ds_src2;
    word_t     ds_store_data;
    reg_addr_t ds_dest;
    logic      ds_gr_we;
    logic      ds_load;
    logic      ds_store;

    // execute to mem/wb
    logic      ms_allowin;
    logic      es_to_ms_valid;
    word_t     es_result;
    word_t     es_store_data;
    reg_addr_t es_dest_out;
    logic      es_gr_we_out;
    logic      es_load_out;
    logic      es_store_out;

    // hazard and forward sideband into decode
    logic      es_we;
    reg_addr_t es_dest;
    logic      es_fwd_valid;
    word_t     es_fwd_data;
    logic      ms_we;
    reg_addr_t ms_dest;
    logic      ms_fwd_valid;
    word_t     ms_fwd_data;
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;

    // requesters on the arbiter
    logic      inst_req;
    word_t     inst_addr;
    logic      inst_ack;
    word_t     inst_rdata;
    logic      data_req;
    logic      data_we;
    word_t     data_addr;
    word_t     data_wdata;
    logic      data_ack;
    word_t     data_rdata;

    // port names match the wires above
    fetch_stage #(.reset_pc(reset_pc)) u_fetch (.*);

    decode_stage u_decode (.*);

    exec_stage u_exec (.*);

    mem_wb_stage u_mem_wb (.*);

    bus_arbiter u_arbiter (.*);

endmodule

// File: design/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // operation carried from decode into execute
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt,
        alu_sll,
        alu_lui
    } alu_op_e;

    // branch class, resolved in decode
    typedef enum logic [2:0] {
        br_none,
        br_beq,
        br_bne,
        br_j,
        br_jr
    } br_op_e;

    typedef enum logic [1:0] {
        arb_idle,
        arb_inst,
        arb_data
    } arb_state_e;

endpackage

// File: design/regfile.sv
`timescale 1ns/1ps

module regfile import mips_pkg::*; (
    input  logic      clk,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata,
    output word_t     rdata1,
    output word_t     rdata2
);
    word_t regs [32];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is hardwired to zero
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

// File: mini_mips.f
design/mips_pkg.sv
design/regfile.sv
design/fetch_stage.sv
design/decode_stage.sv
design/exec_stage.sv
design/mem_wb_stage.sv
design/bus_arbiter.sv
design/mips_core.sv
verif/tb_mips_core.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
out=$(verilator --binary --timing --timescale 1ns/1ps -f mini_mips.f \
    --top-module tb_mips_core -o sim_mini_mips 2>&1 \
    && ./obj_dir/sim_mini_mips 2>&1)
echo "$out"
echo "$out" | grep -q -F '** PASS **' \
    && echo "simulation ok" \
    || { echo "simulation failed"; exit 1; }

// File: verif/mips_patterns.txt
# P <byte addr> <instruction word>: program image
# W <reg> <value>: expected register write, S <addr> <data>: expected store
P 00000000 3c011234
P 00000004 34215678
P 00000008 2402fffd
P 0000000c 00221821
P 00000010 00612023
P 00000014 0080282a
P 00000018 00053100
P 0000001c 00663824
P 00000020 00c54025
P 00000024 24090200
P 00000028 ad230004
P 0000002c 8d2a0004
P 00000030 01455821
P 00000034 116a0005
P 00000038 240c0001
P 0000003c 156a0002
P 00000040 258c0002
P 00000044 258c0100
P 00000048 0c00001c
P 0000004c 240d0007
P 00000050 ad2e0008
P 00000054 8d2f0008
P 00000058 11ee0002
P 0000005c 25f00001
P 00000060 24107777
P 00000064 08000019
P 00000068 00000000
P 00000070 01ac7021
P 00000074 03e00008
P 00000078 000e7040
W 01 12340000
W 01 12345678
W 02 fffffffd
W 03 12345675
W 04 fffffffd
W 05 00000001
W 06 00000010
W 07 00000010
W 08 00000011
W 09 00000200
W 0a 12345675
W 0b 12345676
W 0c 00000001
W 0c 00000003
W 1f 00000050
W 0d 00000007
W 0e 0000000a
W 0e 00000014
W 0f 00000014
W 10 00000015
S 00000204 12345675
S 00000208 00000014

// File: verif/tb_mips_core.sv
`timescale 1ns/1ps

module tb_mips_core import mips_pkg::*;;

    logic      clk = 1'b0;
    logic      reset = 1'b1;
    word_t     mem_rdata = 32'h0;
    logic      mem_ack = 1'b0;
    logic      mem_req;
    logic      mem_we;
    word_t     mem_addr;
    word_t     mem_wdata;
    logic      wb_valid;
    reg_addr_t wb_dest;
    word_t     wb_data;

    // 1 KiB word memory behind the bus
    word_t     mem [256];
    reg_addr_t exp_wb_dest [$];
    word_t     exp_wb_data [$];
    word_t     exp_st_addr [$];
    word_t     exp_st_data [$];

    int        seed = 32'h51a2;
    logic      mem_busy = 1'b0;
    int        lat_left = 0;

    always #5 clk = ~clk;

    mips_core #(.reset_pc(32'h0)) dut (
        .clk       (clk),
        .reset     (reset),
        .mem_rdata (mem_rdata),
        .mem_ack   (mem_ack),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .wb_valid  (wb_valid),
        .wb_dest   (wb_dest),
        .wb_data   (wb_data)
    );

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            stop_with_failure($sformatf("FAIL %s: got %h expected %h", name, got, expected));
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t got,
                             input reg_addr_t expected);
        if (got !== expected) begin
            stop_with_failure($sformatf("FAIL %s: got %h expected %h", name, got, expected));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            stop_with_failure($sformatf("FAIL %s: got %h expected %h", name, got, expected));
        end
    endtask

    task automatic load_memory_image();
        int               fd;
        int               n;
        int               i;
        logic             done;
        logic [7:0]       tag;
        word_t            col_a;
        word_t            col_b;
        logic [8*128-1:0] rest;
        // unused words still differ per address
        for (i = 0; i < 256; i++) begin
            mem[i] = 32'hbad0_0000 | word_t'(i * 4);
        end
        fd = $fopen("verif/mips_patterns.txt", "r");
        if (fd == 0) begin
            stop_with_failure("could not open verif/mips_patterns.txt");
        end
        done = 1'b0;
        while (!done) begin
            n = $fscanf(fd, " %c", tag);
            if (n != 1) begin
                done = 1'b1;
            end else if (tag == "#") begin
                n = $fgets(rest, fd);
            end else begin
                n = $fscanf(fd, "%h %h", col_a, col_b);
                if (n != 2) begin
                    stop_with_failure("pattern file line is missing its two hex values");
                end
                case (tag)
                    "P": begin
                        if (col_a[31:10] != 22'd0) begin
                            stop_with_failure("program word lies outside the memory model");
                        end
                        mem[col_a[9:2]] = col_b;
                    end
                    "W": begin
                        exp_wb_dest.push_back(col_a[4:0]);
                        exp_wb_data.push_back(col_b);
                    end
                    "S": begin
                        exp_st_addr.push_back(col_a);
                        exp_st_data.push_back(col_b);
                    end
                    default: stop_with_failure("pattern file holds an unknown line tag");
                endcase
            end
        end
        $fclose(fd);
        if (exp_wb_dest.size() == 0) begin
            stop_with_failure("pattern file lists no expected register writes");
        end
    endtask

    // memory model answers each request after 0 to 3 cycles
    task automatic serve_memory();
        word_t want_addr;
        word_t want_data;
        if (mem_ack) begin
            mem_ack <= 1'b0;
        end else if (mem_req) begin
            if (!mem_busy) begin
                mem_busy = 1'b1;
                lat_left = $random(seed) & 32'h3;
            end
            if (lat_left != 0) begin
                lat_left = lat_left - 1;
            end else begin
                mem_busy = 1'b0;
                if (mem_addr[31:10] != 22'd0 || mem_addr[1:0] != 2'd0) begin
                    stop_with_failure("bus access outside the aligned memory model");
                end
                mem_ack <= 1'b1;
                if (mem_we) begin
                    if (exp_st_addr.size() == 0) begin
                        stop_with_failure("store on the bus after the expected stores ended");
                    end
                    want_addr = exp_st_addr.pop_front();
                    want_data = exp_st_data.pop_front();
                    check_word("mem_addr", mem_addr, want_addr);
                    check_word("mem_wdata", mem_wdata, want_data);
                    mem[mem_addr[9:2]] = mem_wdata;
                end else begin
                    mem_rdata <= mem[mem_addr[9:2]];
                end
            end
        end else if (mem_busy) begin
            stop_with_failure("mem_req dropped before the memory acknowledged it");
        end
    endtask

    task automatic watch_writeback();
        reg_addr_t want_dest;
        word_t     want_data;
        if (wb_valid) begin
            if (exp_wb_dest.size() == 0) begin
                stop_with_failure("register write after the expected writes ended");
            end
            want_dest = exp_wb_dest.pop_front();
            want_data = exp_wb_data.pop_front();
            check_reg("wb_dest", wb_dest, want_dest);
            check_word("wb_data", wb_data, want_data);
        end
    endtask

    initial begin
        int cycles;
        load_memory_image();
        repeat (3) @(posedge clk);
        check_bit("mem_req", mem_req, 1'b0);
        check_bit("wb_valid", wb_valid, 1'b0);
        reset <= 1'b0;
        cycles = 0;
        while (exp_wb_dest.size() != 0 || exp_st_addr.size() != 0) begin
            @(posedge clk);
            serve_memory();
            watch_writeback();
            cycles = cycles + 1;
            if (cycles > 4000) begin
                stop_with_failure("timeout: expected register writes or stores never came");
            end
        end
        // program now spins on its self-jump and must write nothing more
        cycles = 0;
        while (cycles < 60) begin
            @(posedge clk);
            serve_memory();
            watch_writeback();
            cycles = cycles + 1;
        end
        $display("** PASS **");
        $finish;
    end

endmodule
